//--- tests/platform_golden.txt
# name master op address mask data expected_read expected_invalid
# master p probe or c cpu, op r read w write u uart byte, numbers in hex
uart_status_rst  p r 00000800 0 00000000 00000000 0
w_word0_full     p w 00000000 f 11223344 00000000 0
r_word0_full     p r 00000000 0 00000000 11223344 0
w_word0_byte0    p w 00000000 1 aabbccdd 00000000 0
r_word0_byte0    p r 00000000 0 00000000 112233dd 0
w_word0_mid      p w 00000000 6 a5a5a5a5 00000000 0
r_word0_mid      p r 00000000 0 00000000 11a5a5dd 0
w_word1_full     p w 00000001 f 01010101 00000000 0
w_word5_full     p w 00000005 f 0badf00d 00000000 0
w_word5_low      p w 00000005 3 ffff1234 00000000 0
r_word5_low      p r 00000005 0 00000000 0bad1234 0
w_word200_full   p w 00000200 f 76543210 00000000 0
w_word200_high   p w 00000200 c 9abc0000 00000000 0
r_word200_high   p r 00000200 0 00000000 9abc3210 0
w_word3ff_full   p w 000003ff f deadbeef 00000000 0
w_word3ff_byte3  p w 000003ff 8 01020304 00000000 0
r_word3ff_byte3  p r 000003ff 0 00000000 01adbeef 0
w_probe_word10   p w 00000010 f cafe0001 00000000 0
r_cpu_word10     c r 00000010 0 00000000 cafe0001 0
w_cpu_word11     c w 00000011 f 5eed0002 00000000 0
r_probe_word11   p r 00000011 0 00000000 5eed0002 0
r_cpu_word3ff    c r 000003ff 0 00000000 01adbeef 0
r_invalid_400    p r 00000400 0 00000000 00000000 1
w_invalid_400    p w 00000400 f ffffffff 00000000 1
r_after_400_lo   p r 00000000 0 00000000 11a5a5dd 0
r_after_400_hi   p r 000003ff 0 00000000 01adbeef 0
r_invalid_801    c r 00000801 0 00000000 00000000 1
w_invalid_801    c w 00000801 f 00000000 00000000 1
r_after_801      c r 00000001 0 00000000 01010101 0
uart_probe_a5    p u 00000800 1 000000a5 00000001 0
uart_idle_a5     p r 00000800 0 00000000 00000000 0
uart_cpu_3c      c u 00000800 1 0000003c 00000001 0
uart_idle_3c     c r 00000800 0 00000000 00000000 0

//--- sim.f
hw/mem_bus_pkg.sv
hw/mem_bus_if.sv
hw/master_bus_mux.sv
hw/slave_bus_mux.sv
hw/data_mem.sv
hw/uart_tx.sv
hw/platform_top.sv
tests/tb_clock.sv
tests/platform_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then search the log for the fail message
verilator --binary --timing -Wno-fatal --top-module platform_tb -f sim.f -o platform_sim \
   && ./obj_dir/platform_sim | tee sim.log \
   && ! grep -q "Done: errors found" sim.log \
   && grep -q "Done: no errors" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

//--- tests/platform_tb.sv
`default_nettype none

module platform_tb;

   logic                               clk;
   logic                               rst;
   logic                               probe_mem;
   logic [mem_bus_pkg::addr_width-1:0] probe_address;
   logic                               probe_mem_read;
   logic                               probe_mem_write;
   logic [mem_bus_pkg::mask_width-1:0] probe_mask_byte;
   logic [mem_bus_pkg::data_width-1:0] probe_write_data;
   logic [mem_bus_pkg::data_width-1:0] probe_read_data;
   logic [mem_bus_pkg::addr_width-1:0] cpu_address;
   logic                               cpu_mem_read;
   logic                               cpu_mem_write;
   logic [mem_bus_pkg::mask_width-1:0] cpu_mask_byte;
   logic [mem_bus_pkg::data_width-1:0] cpu_write_data;
   logic [mem_bus_pkg::data_width-1:0] cpu_read_data;
   logic                               invalid_address;
   logic                               tx;

   // one entry per golden line
   string                              name_q[$];
   byte                                master_q[$];
   byte                                op_q[$];
   logic [mem_bus_pkg::addr_width-1:0] addr_q[$];
   logic [mem_bus_pkg::mask_width-1:0] mask_q[$];
   logic [mem_bus_pkg::data_width-1:0] data_q[$];
   logic [mem_bus_pkg::data_width-1:0] exp_rd_q[$];
   logic                               exp_inv_q[$];

   int error_count = 0;
   int failed_tests = 0;
   int test_errors;
   bit loaded = 1'b0;

   tb_clock tb_clock_i (.clk(clk));

   platform_top platform_top_i (
      .clk              (clk),
      .rst              (rst),
      .probe_mem        (probe_mem),
      .probe_address    (probe_address),
      .probe_mem_read   (probe_mem_read),
      .probe_mem_write  (probe_mem_write),
      .probe_mask_byte  (probe_mask_byte),
      .probe_write_data (probe_write_data),
      .probe_read_data  (probe_read_data),
      .cpu_address      (cpu_address),
      .cpu_mem_read     (cpu_mem_read),
      .cpu_mem_write    (cpu_mem_write),
      .cpu_mask_byte    (cpu_mask_byte),
      .cpu_write_data   (cpu_write_data),
      .cpu_read_data    (cpu_read_data),
      .invalid_address  (invalid_address),
      .tx               (tx)
   );

   task automatic check(input string test, input string what,
                        input logic [31:0] expected, input logic [31:0] actual);
      if (actual !== expected) begin
         $display("mismatch %s %s: expected %h, actual %h", test, what, expected, actual);
         error_count++;
         test_errors++;
      end
   endtask

   function automatic logic [31:0] read_of(input byte master);
      return (master == "p") ? probe_read_data : cpu_read_data;
   endfunction

   // the unselected port mirrors the strobes with inverted fields
   // so a wrong select shows up as a bad address or a changed word
   task automatic drive(input byte master, input logic rd, input logic wr,
                        input logic [29:0] addr, input logic [3:0] mask,
                        input logic [31:0] data);
      logic sel_probe;
      sel_probe        = (master == "p");
      probe_mem        = sel_probe;
      probe_address    = sel_probe ? addr : ~addr;
      probe_mem_read   = rd;
      probe_mem_write  = wr;
      probe_mask_byte  = sel_probe ? mask : ~mask;
      probe_write_data = sel_probe ? data : ~data;
      cpu_address      = sel_probe ? ~addr : addr;
      cpu_mem_read     = rd;
      cpu_mem_write    = wr;
      cpu_mask_byte    = sel_probe ? ~mask : mask;
      cpu_write_data   = sel_probe ? ~data : data;
   endtask

   // ============================================================
   // bus operations
   // ============================================================
   // returns on the falling edge after the strobe, read data is valid there
   task automatic bus_cycle(input byte master, input logic rd, input logic wr,
                            input logic [29:0] addr, input logic [3:0] mask,
                            input logic [31:0] data, output logic inv);
      @(negedge clk);
      drive(master, rd, wr, addr, mask, data);
      @(posedge clk);
      inv = invalid_address;
      @(negedge clk);
      drive(master, 1'b0, 1'b0, addr, mask, data);
   endtask

   task automatic send_uart(input int i);
      logic        inv;
      logic [10:0] frame;
      int          cpb;
      int          n;
      cpb = mem_bus_pkg::uart_clks_per_bit;
      // idle, stop, data lsb first, start
      frame = {2'b11, data_q[i][7:0], 1'b0};
      bus_cycle(master_q[i], 1'b0, 1'b1, addr_q[i], mask_q[i], data_q[i], inv);
      check(name_q[i], "invalid_address", {31'b0, exp_inv_q[i]}, {31'b0, inv});
      // n counts falling edges after the write edge
      for (n = 0; n < 11 * cpb; n++) begin
         if (n > 0)
            @(negedge clk);
         if (n % cpb == cpb / 2)
            check(name_q[i], $sformatf("tx bit %0d", n / cpb),
                  {31'b0, frame[n / cpb]}, {31'b0, tx});
         if (n == 2 * cpb + 1)
            check(name_q[i], "busy status", exp_rd_q[i], read_of(master_q[i]));
         // status read in bit 2, a second write in bit 4 that must be dropped
         drive(master_q[i], n == 2 * cpb, n == 4 * cpb, addr_q[i], mask_q[i], ~data_q[i]);
      end
   endtask

   task automatic report(input string name);
      if (test_errors == 0) begin
         $display("%s: ok", name);
      end else begin
         $display("%s: failed", name);
         failed_tests++;
      end
   endtask

   task automatic run_test(input int i);
      logic inv;
      test_errors = 0;
      case (op_q[i])
         "r", "w": begin
            bus_cycle(master_q[i], op_q[i] == "r", op_q[i] == "w",
                      addr_q[i], mask_q[i], data_q[i], inv);
            check(name_q[i], "invalid_address", {31'b0, exp_inv_q[i]}, {31'b0, inv});
            if (op_q[i] == "r") begin
               check(name_q[i], "read_data", exp_rd_q[i], read_of(master_q[i]));
               check(name_q[i], "other master read_data", 32'd0,
                     read_of(master_q[i] == "p" ? "c" : "p"));
            end
         end
         "u": send_uart(i);
         default: begin
            $display("test %s has an unknown operation", name_q[i]);
            error_count++;
            test_errors++;
         end
      endcase
      report(name_q[i]);
   endtask

   // ============================================================
   // golden file
   // ============================================================
   task automatic load_golden(output bit ok);
      int          fd;
      int          code;
      int          c;
      string       name;
      string       master;
      string       op;
      logic [29:0] addr;
      logic [3:0]  mask;
      logic [31:0] data;
      logic [31:0] exp_rd;
      logic        exp_inv;
      ok = 1'b1;
      fd = $fopen("tests/platform_golden.txt", "r");
      if (fd == 0) begin
         $display("cannot open tests/platform_golden.txt");
         ok = 1'b0;
      end else begin
         while (ok && $fscanf(fd, "%s", name) == 1) begin
            if (name.getc(0) == "#") begin
               c = $fgetc(fd);
               while (c != 10 && c != -1)
                  c = $fgetc(fd);
            end else begin
               code = $fscanf(fd, "%s %s %h %h %h %h %h",
                              master, op, addr, mask, data, exp_rd, exp_inv);
               if (code != 7 || (master != "p" && master != "c")) begin
                  $display("golden file entry %s is malformed", name);
                  ok = 1'b0;
               end else begin
                  name_q.push_back(name);
                  master_q.push_back(master.getc(0));
                  op_q.push_back(op.getc(0));
                  addr_q.push_back(addr);
                  mask_q.push_back(mask);
                  data_q.push_back(data);
                  exp_rd_q.push_back(exp_rd);
                  exp_inv_q.push_back(exp_inv);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   initial begin
      bit ok;
      rst = 1'b1;
      drive("p", 1'b0, 1'b0, '0, '0, '0);
      load_golden(ok);
      if (!ok) begin
         $display("golden file could not be loaded, no tests run");
         $display("Done: errors found");
         $finish;
      end else begin
         loaded = 1'b1;
         repeat (16) @(posedge clk);
         @(negedge clk);
         rst = 1'b0;
         // idle line and cleared read ports out of reset
         test_errors = 0;
         check("reset_state", "tx", 32'd1, {31'b0, tx});
         check("reset_state", "probe_read_data", 32'd0, probe_read_data);
         check("reset_state", "cpu_read_data", 32'd0, cpu_read_data);
         report("reset_state");
         for (int i = 0; i < name_q.size(); i++)
            run_test(i);
         $display("%0d tests, %0d failed, %0d check errors",
                  name_q.size() + 1, failed_tests, error_count);
         if (error_count == 0)
            $display("Done: no errors");
         else
            $display("Done: errors found");
         $finish;
      end
   end

   initial begin
      int limit;
      wait (loaded);
      limit = name_q.size() * 64 + 200;
      repeat (limit) @(posedge clk);
      $display("watchdog expired after %0d cycles, tests did not finish", limit);
      $display("Done: errors found");
      $finish;
   end

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
`default_nettype none

module tb_clock (
   output logic clk
);

   initial begin
      clk = 1'b0;
   end

   // period of 10
   always #5 clk = ~clk;

endmodule

`default_nettype wire

//--- hw/platform_top.sv
`default_nettype none

module platform_top (
   input logic                                clk,
   input logic                                rst,
   input logic                                probe_mem,

   input logic  [mem_bus_pkg::addr_width-1:0] probe_address,
   input logic                                probe_mem_read,
   input logic                                probe_mem_write,
   input logic  [mem_bus_pkg::mask_width-1:0] probe_mask_byte,
   input logic  [mem_bus_pkg::data_width-1:0] probe_write_data,
   output logic [mem_bus_pkg::data_width-1:0] probe_read_data,

   input logic  [mem_bus_pkg::addr_width-1:0] cpu_address,
   input logic                                cpu_mem_read,
   input logic                                cpu_mem_write,
   input logic  [mem_bus_pkg::mask_width-1:0] cpu_mask_byte,
   input logic  [mem_bus_pkg::data_width-1:0] cpu_write_data,
   output logic [mem_bus_pkg::data_width-1:0] cpu_read_data,

   output logic                               invalid_address,
   output logic                               tx
);

   mem_bus_if probe_bus ();
   mem_bus_if cpu_bus ();
   mem_bus_if memory_bus ();
   mem_bus_if data_bus ();
   mem_bus_if uart_bus ();

   // ============================================================
   // masters
   // ============================================================
   assign probe_bus.address    = probe_address;
   assign probe_bus.mem_read   = probe_mem_read;
   assign probe_bus.mem_write  = probe_mem_write;
   assign probe_bus.mask_byte  = probe_mask_byte;
   assign probe_bus.write_data = probe_write_data;
   assign probe_read_data      = probe_bus.read_data;

   // cpu data port stands in for the core
   assign cpu_bus.address    = cpu_address;
   assign cpu_bus.mem_read   = cpu_mem_read;
   assign cpu_bus.mem_write  = cpu_mem_write;
   assign cpu_bus.mask_byte  = cpu_mask_byte;
   assign cpu_bus.write_data = cpu_write_data;
   assign cpu_read_data      = cpu_bus.read_data;

   // probe_mem high hands the bus to the probe
   master_bus_mux master_bus_mux_i (
      .clk        (clk),
      .rst        (rst),
      .use_a      (probe_mem),
      .bus_a      (probe_bus),
      .bus_b      (cpu_bus),
      .bus_common (memory_bus)
   );

   // ============================================================
   // slaves
   // ============================================================
   slave_bus_mux slave_bus_mux_i (
      .clk             (clk),
      .rst             (rst),
      .bus_in          (memory_bus),
      .bus_mem         (data_bus),
      .bus_uart        (uart_bus),
      .invalid_address (invalid_address)
   );

   data_mem data_mem_i (
      .clk (clk),
      .bus (data_bus)
   );

   uart_tx uart_tx_i (
      .clk (clk),
      .rst (rst),
      .bus (uart_bus),
      .tx  (tx)
   );

endmodule

`default_nettype wire

//--- hw/uart_tx.sv
`default_nettype none

module uart_tx (
   input logic        clk,
   input logic        rst,
   mem_bus_if.slave   bus,
   output logic       tx
);

   logic [9:0]                                        shift_q;
   logic [$clog2(mem_bus_pkg::uart_clks_per_bit)-1:0] clk_cnt;
   logic [3:0]                                        bit_cnt;
   logic                                              busy;
   logic                                              start;
   logic                                              bit_done;

   // a write while a frame is on the line is dropped
   assign start = bus.mem_write & bus.mask_byte[0] & ~busy;

   assign bit_done = clk_cnt ==
      $bits(clk_cnt)'(mem_bus_pkg::uart_clks_per_bit - 1);

   // ============================================================
   // transmitter
   // ============================================================
   // idle line sits at the stop level, ones shift in behind the frame
   always_ff @(posedge clk) begin
      if (rst) begin
         shift_q <= '1;
         clk_cnt <= '0;
         bit_cnt <= '0;
         busy    <= 1'b0;
      end else if (start) begin
         // stop, data lsb first, start
         shift_q <= {1'b1, bus.write_data[7:0], 1'b0};
         clk_cnt <= '0;
         bit_cnt <= '0;
         busy    <= 1'b1;
      end else if (busy) begin
         if (bit_done) begin
            clk_cnt <= '0;
            shift_q <= {1'b1, shift_q[9:1]};
            bit_cnt <= bit_cnt + 4'd1;
            if (bit_cnt == 4'd9) begin
               busy <= 1'b0;   // end of stop bit
            end
         end else begin
            clk_cnt <= clk_cnt + 1'b1;
         end
      end
   end

   assign tx = shift_q[0];

   // ============================================================
   // status read
   // ============================================================
   always_ff @(posedge clk) begin
      if (rst) begin
         bus.read_data <= '0;
      end else if (bus.mem_read) begin
         bus.read_data <= {{(mem_bus_pkg::data_width-1){1'b0}}, busy};
      end
   end

endmodule

`default_nettype wire

//--- hw/data_mem.sv
`default_nettype none

module data_mem (
   input logic        clk,
   mem_bus_if.slave   bus
);

   logic [mem_bus_pkg::data_width-1:0] mem [mem_bus_pkg::mem_words];
   logic [$clog2(mem_bus_pkg::mem_words)-1:0] word_index;

   // the decoder already passed an offset inside the memory
   assign word_index = bus.address[$clog2(mem_bus_pkg::mem_words)-1:0];

   // byte-masked write
   always_ff @(posedge clk) begin
      if (bus.mem_write) begin
         for (int i = 0; i < mem_bus_pkg::mask_width; i++) begin
            if (bus.mask_byte[i]) begin
               mem[word_index][8*i +: 8] <= bus.write_data[8*i +: 8];
            end
         end
      end
   end

   // registered read, held until the next read strobe
   always_ff @(posedge clk) begin
      if (bus.mem_read) begin
         bus.read_data <= mem[word_index];
      end
   end

endmodule

`default_nettype wire

//--- hw/slave_bus_mux.sv
`default_nettype none

module slave_bus_mux (
   input logic         clk,
   input logic         rst,
   mem_bus_if.slave    bus_in,
   mem_bus_if.master   bus_mem,
   mem_bus_if.master   bus_uart,
   output logic        invalid_address
);

   logic [mem_bus_pkg::addr_width-1:0] mem_offset;
   logic [mem_bus_pkg::addr_width-1:0] uart_offset;
   logic                               mem_hit;
   logic                               uart_hit;
   logic                               read_mem_q;
   logic                               read_uart_q;

   // ============================================================
   // address decode
   // ============================================================
   // the subtraction wraps below the base, so one compare covers both bounds
   assign mem_offset  = bus_in.address - mem_bus_pkg::addr_width'(mem_bus_pkg::mem_base);
   assign uart_offset = bus_in.address - mem_bus_pkg::addr_width'(mem_bus_pkg::uart_base);
   assign mem_hit     = mem_offset < mem_bus_pkg::addr_width'(mem_bus_pkg::mem_words);
   assign uart_hit    = uart_offset < mem_bus_pkg::addr_width'(mem_bus_pkg::uart_words);

   assign invalid_address = (bus_in.mem_read | bus_in.mem_write) & ~mem_hit & ~uart_hit;

   // ============================================================
   // command fan-out
   // ============================================================
   always_comb begin
      bus_mem.address     = mem_offset;
      bus_mem.mem_read    = bus_in.mem_read & mem_hit;
      bus_mem.mem_write   = bus_in.mem_write & mem_hit;
      bus_mem.mask_byte   = bus_in.mask_byte;
      bus_mem.write_data  = bus_in.write_data;

      bus_uart.address    = uart_offset;
      bus_uart.mem_read   = bus_in.mem_read & uart_hit;
      bus_uart.mem_write  = bus_in.mem_write & uart_hit;
      bus_uart.mask_byte  = bus_in.mask_byte;
      bus_uart.write_data = bus_in.write_data;
   end

   // ============================================================
   // read data return
   // ============================================================
   // region of the last read, held so the data stays until the next one
   always_ff @(posedge clk) begin
      if (rst) begin
         read_mem_q  <= 1'b0;
         read_uart_q <= 1'b0;
      end else if (bus_in.mem_read) begin
         read_mem_q  <= mem_hit;
         read_uart_q <= uart_hit;
      end
   end

   always_comb begin
      if (read_mem_q)
         bus_in.read_data = bus_mem.read_data;
      else if (read_uart_q)
         bus_in.read_data = bus_uart.read_data;
      else
         bus_in.read_data = '0;   // invalid address or no read yet
   end

endmodule

`default_nettype wire

//--- hw/master_bus_mux.sv
`default_nettype none

module master_bus_mux (
   input logic         clk,
   input logic         rst,
   input logic         use_a,
   mem_bus_if.slave    bus_a,
   mem_bus_if.slave    bus_b,
   mem_bus_if.master   bus_common
);

   logic sel_read;
   logic use_a_q;

   // only the selected master reaches the common bus
   always_comb begin
      sel_read               = use_a ? bus_a.mem_read : bus_b.mem_read;
      bus_common.address     = use_a ? bus_a.address : bus_b.address;
      bus_common.mem_read    = sel_read;
      bus_common.mem_write   = use_a ? bus_a.mem_write : bus_b.mem_write;
      bus_common.mask_byte   = use_a ? bus_a.mask_byte : bus_b.mask_byte;
      bus_common.write_data  = use_a ? bus_a.write_data : bus_b.write_data;
   end

   // remember who asked, so the answer goes back to that master
   always_ff @(posedge clk) begin
      if (rst) begin
         use_a_q <= 1'b1;
      end else if (sel_read) begin
         use_a_q <= use_a;
      end
   end

   assign bus_a.read_data = use_a_q ? bus_common.read_data : '0;
   assign bus_b.read_data = use_a_q ? '0 : bus_common.read_data;

endmodule

`default_nettype wire

//--- hw/mem_bus_if.sv
`default_nettype none

interface mem_bus_if;

   logic [mem_bus_pkg::addr_width-1:0] address;
   logic                               mem_read;
   logic                               mem_write;
   logic [mem_bus_pkg::mask_width-1:0] mask_byte;
   logic [mem_bus_pkg::data_width-1:0] write_data;
   logic [mem_bus_pkg::data_width-1:0] read_data;

   // the master issues commands, the slave answers reads
   modport master (
      output address, mem_read, mem_write, mask_byte, write_data,
      input  read_data
   );

   modport slave (
      input  address, mem_read, mem_write, mask_byte, write_data,
      output read_data
   );

endinterface

`default_nettype wire

//--- hw/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

   // ============================================================
   // bus widths
   // ============================================================
   localparam int addr_width = 30;   // word address
   localparam int data_width = 32;
   localparam int mask_width = 4;    // one enable per byte

   // ============================================================
   // slave address map, in words
   // ============================================================
   localparam int mem_base   = 0;
   localparam int mem_words  = 1024;
   localparam int uart_base  = 'h800;
   localparam int uart_words = 1;

   // ============================================================
   // uart timing
   // ============================================================
   localparam int uart_clks_per_bit = 4;

endpackage

`default_nettype wire
